/* list.f */
video_pkg.sv
pixel_counter.sv
vga_timing_gen.sv
pattern_gen.sv
palette_lut.sv
sync_delay.sv
vga_top.sv
tb_clock_gen.sv
vga_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= vga_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^NO ERRORS$$" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* vga_tb.sv */
`timescale 1ns/1ps

module vga_tb;

    localparam int H_VIS      = 16;
    localparam int H_FP       = 2;
    localparam int H_SYNC     = 4;
    localparam int H_BP       = 2;
    localparam int V_VIS      = 8;
    localparam int V_FP       = 1;
    localparam int V_SYNC     = 2;
    localparam int V_BP       = 1;
    localparam int CELL_SHIFT = 1;

    localparam int H_TOTAL      = H_VIS + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL      = V_VIS + V_FP + V_SYNC + V_BP;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

    typedef struct packed {
        video_pkg::pattern_e pat;
        logic                mid_change;  // move pattern_sel in the middle of each frame.
        video_pkg::pattern_e mid_pat;
        logic                we;
        logic [3:0]          addr;
        logic                rand_colour;
        logic [11:0]         colour;
        logic [3:0]          frames;
    } row_t;

    logic                              clk;
    logic                              rst_n;
    video_pkg::pattern_e               pattern_sel;
    logic                              pal_we;
    logic [video_pkg::PAL_IDX_W-1:0]   pal_addr;
    video_pkg::rgb_t                   pal_data;
    video_pkg::rgb_t                   rgb;
    logic                              h_sync;
    logic                              v_sync;

    row_t        rows [$];
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          timeout_limit = 1000000;
    logic [31:0] lcg_state = 32'd56040;

    int                  mx;
    int                  my;
    video_pkg::pattern_e cur_pat_m;
    logic [11:0]         pal_model [16];
    logic [3:0]          idx_d1;
    logic                vis_d1;
    logic                hs_d1;
    logic                hs_d2;
    logic                vs_d1;
    logic                vs_d2;
    logic [11:0]         exp_rgb;

    tb_clock_gen #(
        .PERIOD_NS   (4),
        .RESET_CYCLES(2)
    ) u_clk_gen (
        .clk  (clk),
        .rst_n(rst_n)
    );

    vga_top #(
        .H_VIS     (H_VIS),
        .H_FP      (H_FP),
        .H_SYNC    (H_SYNC),
        .H_BP      (H_BP),
        .V_VIS     (V_VIS),
        .V_FP      (V_FP),
        .V_SYNC    (V_SYNC),
        .V_BP      (V_BP),
        .CELL_SHIFT(CELL_SHIFT)
    ) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .pattern_sel(pattern_sel),
        .pal_we     (pal_we),
        .pal_addr   (pal_addr),
        .pal_data   (pal_data),
        .rgb        (rgb),
        .h_sync     (h_sync),
        .v_sync     (v_sync)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        end
    endtask

    function automatic logic [11:0] random_colour();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[27:16];
    endfunction

    function automatic logic [3:0] expected_index(input video_pkg::pattern_e pat,
                                                  input int px, input int py);
        int cx;
        int cy;
        cx = px >> CELL_SHIFT;
        cy = py >> CELL_SHIFT;
        case (pat)
            video_pkg::PAT_SOLID:   return 4'd15;
            video_pkg::PAT_BARS:    return 4'(cx % 16);
            video_pkg::PAT_CHECKER: return ((cx % 2) != (cy % 2)) ? 4'd15 : 4'd0;
            default:                return 4'(cy % 16);
        endcase
    endfunction

    function automatic row_t make_row(input video_pkg::pattern_e pat, input logic mid_change,
                                      input video_pkg::pattern_e mid_pat, input logic we,
                                      input logic [3:0] addr, input logic rand_colour,
                                      input logic [11:0] colour, input logic [3:0] frames);
        row_t r;
        r.pat         = pat;
        r.mid_change  = mid_change;
        r.mid_pat     = mid_pat;
        r.we          = we;
        r.addr        = addr;
        r.rand_colour = rand_colour;
        r.colour      = colour;
        r.frames      = frames;
        return r;
    endfunction

    // advances the reference raster by one clock on the falling edge.
    task automatic model_step();
        logic [11:0]         next_rgb;
        logic                frame_start_m;
        video_pkg::pattern_e act_pat;

        check_value("rgb", 32'(exp_rgb), 32'(rgb));
        check_value("h_sync", 32'(hs_d2), 32'(h_sync));
        check_value("v_sync", 32'(vs_d2), 32'(v_sync));

        next_rgb = vis_d1 ? pal_model[idx_d1] : 12'h000; // this cycle's write is not seen yet.
        if (pal_we) begin
            pal_model[pal_addr] = pal_data;
        end

        frame_start_m = (mx == 0) && (my == 0);
        act_pat = frame_start_m ? pattern_sel : cur_pat_m;
        if (frame_start_m) begin
            cur_pat_m = pattern_sel;
        end

        idx_d1 = expected_index(act_pat, mx, my);
        vis_d1 = (mx < H_VIS) && (my < V_VIS);
        hs_d2 = hs_d1;
        vs_d2 = vs_d1;
        hs_d1 = !((mx >= H_VIS + H_FP) && (mx < H_VIS + H_FP + H_SYNC));
        vs_d1 = !((my >= V_VIS + V_FP) && (my < V_VIS + V_FP + V_SYNC));
        exp_rgb = next_rgb;

        if (mx == H_TOTAL - 1) begin
            mx = 0;
            my = (my == V_TOTAL - 1) ? 0 : my + 1;
        end else begin
            mx = mx + 1;
        end
    endtask

    task automatic wait_for_pos(input int px, input int py);
        do begin
            @(posedge clk);
        end while (!(mx == px && my == py));
    endtask

    task automatic apply_row(input row_t r);
        wait_for_pos(1, V_VIS); // vertical blank.
        if (r.we) begin
            pal_we   <= 1'b1;
            pal_addr <= r.addr;
            if (r.rand_colour) begin
                pal_data <= video_pkg::rgb_t'(random_colour());
            end else begin
                pal_data <= video_pkg::rgb_t'(r.colour);
            end
            @(posedge clk);
            pal_we <= 1'b0;
        end
        wait_for_pos(0, V_TOTAL - 1);
        pattern_sel <= r.pat;
        for (int f = 0; f < int'(r.frames); f++) begin
            wait_for_pos(0, V_VIS / 2);
            if (r.mid_change) begin
                pattern_sel <= r.mid_pat; // only picked up at the next frame_start.
            end
        end
    endtask

    initial begin : reference_model
        mx        = 0;
        my        = 0;
        cur_pat_m = video_pkg::PAT_SOLID;
        idx_d1    = '0;
        vis_d1    = 1'b0;
        hs_d1     = 1'b1;
        hs_d2     = 1'b1;
        vs_d1     = 1'b1;
        vs_d2     = 1'b1;
        exp_rgb   = '0;
        for (int i = 0; i < 16; i++) begin
            pal_model[i] = {4'(i), 4'(i), 4'(i)};
        end
        wait (rst_n === 1'b1);
        forever begin
            model_step();
            @(negedge clk);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin : stimulus
        int table_frames;
        table_frames = 0;
        pattern_sel  = video_pkg::PAT_SOLID;
        pal_we       = 1'b0;
        pal_addr     = '0;
        pal_data     = '0;

        rows.push_back(make_row(video_pkg::PAT_SOLID, 1'b0, video_pkg::PAT_SOLID,
                                1'b0, 4'd0, 1'b0, 12'h000, 4'd1));
        rows.push_back(make_row(video_pkg::PAT_BARS, 1'b0, video_pkg::PAT_BARS,
                                1'b0, 4'd0, 1'b0, 12'h000, 4'd1));
        rows.push_back(make_row(video_pkg::PAT_CHECKER, 1'b0, video_pkg::PAT_CHECKER,
                                1'b0, 4'd0, 1'b0, 12'h000, 4'd1));
        rows.push_back(make_row(video_pkg::PAT_GRADIENT, 1'b0, video_pkg::PAT_GRADIENT,
                                1'b0, 4'd0, 1'b0, 12'h000, 4'd1));
        rows.push_back(make_row(video_pkg::PAT_BARS, 1'b0, video_pkg::PAT_BARS,
                                1'b1, 4'd3, 1'b0, 12'hf00, 4'd1));
        rows.push_back(make_row(video_pkg::PAT_BARS, 1'b0, video_pkg::PAT_BARS,
                                1'b1, 4'd5, 1'b1, 12'h000, 4'd1));
        rows.push_back(make_row(video_pkg::PAT_CHECKER, 1'b1, video_pkg::PAT_GRADIENT,
                                1'b1, 4'd15, 1'b1, 12'h000, 4'd2));
        rows.push_back(make_row(video_pkg::PAT_GRADIENT, 1'b1, video_pkg::PAT_SOLID,
                                1'b1, 4'd0, 1'b0, 12'h0a5, 4'd2));
        rows.push_back(make_row(video_pkg::PAT_SOLID, 1'b0, video_pkg::PAT_SOLID,
                                1'b1, 4'd15, 1'b0, 12'h123, 4'd1));

        foreach (rows[i]) table_frames += int'(rows[i].frames);
        timeout_limit = (table_frames + 2) * FRAME_CYCLES + 100; // lead-in and drain frames.

        wait (rst_n === 1'b1);
        foreach (rows[i]) apply_row(rows[i]);

        wait_for_pos(0, V_VIS);
        repeat (FRAME_CYCLES) @(posedge clk);

        if (check_count == 0) begin
            $display("no output was checked by the reference model");
        end
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // rst_n rises on a falling clock edge.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* vga_top.sv */
`timescale 1ns/1ps

module vga_top #(
    parameter int H_VIS      = 640,
    parameter int H_FP       = 16,
    parameter int H_SYNC     = 96,
    parameter int H_BP       = 48,

    parameter int V_VIS      = 480,
    parameter int V_FP       = 10,
    parameter int V_SYNC     = 2,
    parameter int V_BP       = 33,

    parameter int CELL_SHIFT = 5
) (
    input  logic                              clk,
    input  logic                              rst_n,

    input  video_pkg::pattern_e               pattern_sel,

    input  logic                              pal_we,
    input  logic [video_pkg::PAL_IDX_W-1:0]   pal_addr,
    input  video_pkg::rgb_t                   pal_data,

    output video_pkg::rgb_t                   rgb,
    output logic                              h_sync,
    output logic                              v_sync
);

    localparam int X_W          = $clog2(H_VIS + H_FP + H_SYNC + H_BP);
    localparam int Y_W          = $clog2(V_VIS + V_FP + V_SYNC + V_BP);
    localparam int PIPE_LATENCY = 2; // pattern stage plus palette stage.

    logic [X_W-1:0]                    x;
    logic [Y_W-1:0]                    y;
    video_pkg::sync_t                  raw_sync;
    video_pkg::sync_t                  dly_sync;
    logic                              frame_start;
    logic [video_pkg::PAL_IDX_W-1:0]   pal_idx;
    logic                              pix_visible;

    vga_timing_gen #(
        .H_VIS (H_VIS),
        .H_FP  (H_FP),
        .H_SYNC(H_SYNC),
        .H_BP  (H_BP),
        .V_VIS (V_VIS),
        .V_FP  (V_FP),
        .V_SYNC(V_SYNC),
        .V_BP  (V_BP)
    ) u_timing (
        .clk        (clk),
        .rst_n      (rst_n),
        .x          (x),
        .y          (y),
        .raw_sync   (raw_sync),
        .frame_start(frame_start)
    );

    pattern_gen #(
        .X_W       (X_W),
        .Y_W       (Y_W),
        .CELL_SHIFT(CELL_SHIFT)
    ) u_pattern (
        .clk        (clk),
        .rst_n      (rst_n),
        .x          (x),
        .y          (y),
        .h_visible  (raw_sync.h_visible),
        .v_visible  (raw_sync.v_visible),
        .frame_start(frame_start),
        .pattern_sel(pattern_sel),
        .pal_idx    (pal_idx),
        .pix_visible(pix_visible)
    );

    palette_lut u_palette (
        .clk        (clk),
        .rst_n      (rst_n),
        .pal_idx    (pal_idx),
        .pix_visible(pix_visible),
        .pal_we     (pal_we),
        .pal_addr   (pal_addr),
        .pal_data   (pal_data),
        .rgb        (rgb)
    );

    sync_delay #(
        .LENGTH(PIPE_LATENCY)
    ) u_sync_dly (
        .clk     (clk),
        .rst_n   (rst_n),
        .sync_in (raw_sync),
        .sync_out(dly_sync)
    );

    assign h_sync = dly_sync.h_sync;
    assign v_sync = dly_sync.v_sync;

endmodule

/* sync_delay.sv */
`timescale 1ns/1ps

module sync_delay #(
    parameter int LENGTH = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  video_pkg::sync_t   sync_in,
    output video_pkg::sync_t   sync_out
);

    // idle value has both syncs high and nothing visible.
    localparam video_pkg::sync_t SYNC_IDLE = '{
        h_sync:    1'b1,
        v_sync:    1'b1,
        h_visible: 1'b0,
        v_visible: 1'b0
    };

    if (LENGTH < 1) begin : g_bad_length
        $error("sync_delay: LENGTH must be at least 1");
    end

    video_pkg::sync_t stage [LENGTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < LENGTH; i++) begin
                stage[i] <= SYNC_IDLE;
            end
        end else begin
            stage[0] <= sync_in;
            for (int i = 1; i < LENGTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign sync_out = stage[LENGTH-1];

endmodule

/* palette_lut.sv */
`timescale 1ns/1ps

module palette_lut (
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic [video_pkg::PAL_IDX_W-1:0]   pal_idx,
    input  logic                              pix_visible,

    input  logic                              pal_we,
    input  logic [video_pkg::PAL_IDX_W-1:0]   pal_addr,
    input  video_pkg::rgb_t                   pal_data,

    output video_pkg::rgb_t                   rgb
);

    localparam int DEPTH = 2 ** video_pkg::PAL_IDX_W;

    video_pkg::rgb_t pal_mem [DEPTH];

    // default table is a grey ramp.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                pal_mem[i] <= '{r: 4'(i), g: 4'(i), b: 4'(i)};
            end
        end else if (pal_we) begin
            pal_mem[pal_addr] <= pal_data; // seen from the next cycle.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rgb <= '0;
        end else if (pix_visible) begin
            rgb <= pal_mem[pal_idx];
        end else begin
            rgb <= '0; // blanking.
        end
    end

    a_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        pal_we |-> !$isunknown(pal_addr)
    ) else $error("palette_lut: write with unknown address");

endmodule

/* pattern_gen.sv */
`timescale 1ns/1ps

module pattern_gen #(
    parameter int X_W        = 10,
    parameter int Y_W        = 10,
    parameter int CELL_SHIFT = 5
) (
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic [X_W-1:0]                    x,
    input  logic [Y_W-1:0]                    y,
    input  logic                              h_visible,
    input  logic                              v_visible,
    input  logic                              frame_start,
    input  video_pkg::pattern_e               pattern_sel,

    output logic [video_pkg::PAL_IDX_W-1:0]   pal_idx,
    output logic                              pix_visible
);

    localparam int IDX_W = video_pkg::PAL_IDX_W;

    video_pkg::pattern_e cur_pat;
    video_pkg::pattern_e act_pat;
    logic [X_W-1:0]      x_cell;
    logic [Y_W-1:0]      y_cell;
    logic [IDX_W-1:0]    idx_next;

    // pattern only changes on a frame boundary.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_pat <= video_pkg::PAT_SOLID;
        end else if (frame_start) begin
            cur_pat <= pattern_sel;
        end
    end

    // first pixel of the frame already sees the new select.
    assign act_pat = frame_start ? pattern_sel : cur_pat;

    assign x_cell = x >> CELL_SHIFT;
    assign y_cell = y >> CELL_SHIFT;

    always_comb begin
        case (act_pat)
            video_pkg::PAT_SOLID:    idx_next = '1;
            video_pkg::PAT_BARS:     idx_next = IDX_W'(x_cell); // modulo 16.
            video_pkg::PAT_CHECKER:  idx_next = {IDX_W{x_cell[0] ^ y_cell[0]}};
            video_pkg::PAT_GRADIENT: idx_next = IDX_W'(y_cell);
            default:                 idx_next = '1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pal_idx     <= '0;
            pix_visible <= 1'b0;
        end else begin
            pal_idx     <= idx_next;
            pix_visible <= h_visible && v_visible;
        end
    end

endmodule

/* vga_timing_gen.sv */
`timescale 1ns/1ps

module vga_timing_gen #(
    parameter int H_VIS  = 640,
    parameter int H_FP   = 16,
    parameter int H_SYNC = 96,
    parameter int H_BP   = 48,

    parameter int V_VIS  = 480,
    parameter int V_FP   = 10,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 33,

    localparam int H_TOTAL = H_VIS + H_FP + H_SYNC + H_BP,
    localparam int V_TOTAL = V_VIS + V_FP + V_SYNC + V_BP,
    localparam int X_W     = $clog2(H_TOTAL),
    localparam int Y_W     = $clog2(V_TOTAL)
) (
    input  logic               clk,
    input  logic               rst_n,

    output logic [X_W-1:0]     x,
    output logic [Y_W-1:0]     y,

    output video_pkg::sync_t   raw_sync,
    output logic               frame_start
);

    localparam int H_SYNC_START = H_VIS + H_FP;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int V_SYNC_START = V_VIS + V_FP;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    logic h_end;
    logic v_end;
    logic h_sync_act;
    logic v_sync_act;

    assign h_end = (int'(x) == H_TOTAL - 1); // last pixel of the line.
    assign v_end = (int'(y) == V_TOTAL - 1); // last line of the frame.

    pixel_counter #(
        .WIDTH(X_W)
    ) u_h_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .enable(1'b1),
        .clear (h_end),
        .count (x)
    );

    pixel_counter #(
        .WIDTH(Y_W)
    ) u_v_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .enable(h_end),
        .clear (h_end && v_end),
        .count (y)
    );

    assign h_sync_act = (int'(x) >= H_SYNC_START) && (int'(x) < H_SYNC_END);
    assign v_sync_act = (int'(y) >= V_SYNC_START) && (int'(y) < V_SYNC_END);

    always_comb begin
        raw_sync.h_sync    = !h_sync_act;
        raw_sync.v_sync    = !v_sync_act;
        raw_sync.h_visible = (int'(x) < H_VIS);
        raw_sync.v_visible = (int'(y) < V_VIS);
    end

    assign frame_start = (x == '0) && (y == '0);

    a_x_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        int'(x) < H_TOTAL
    ) else $error("vga_timing_gen: x out of range");

    a_y_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        int'(y) < V_TOTAL
    ) else $error("vga_timing_gen: y out of range");

endmodule

/* pixel_counter.sv */
`timescale 1ns/1ps

module pixel_counter #(
    parameter int WIDTH = 10
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             enable,
    input  logic             clear,
    output logic [WIDTH-1:0] count
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0; // clear wins over enable.
        end else if (enable) begin
            count <= count + 1'b1;
        end
    end

    // the wrap condition clears the count before it would roll over on its own.
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        (enable && !clear) |-> (count != '1)
    ) else $error("pixel_counter: count would roll over without a clear");

endmodule

/* video_pkg.sv */
package video_pkg;

    // palette index width for 16 entries.
    parameter int PAL_IDX_W = 4;

    typedef enum logic [1:0] {
        PAT_SOLID    = 2'd0,
        PAT_BARS     = 2'd1,
        PAT_CHECKER  = 2'd2,
        PAT_GRADIENT = 2'd3
    } pattern_e;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef struct packed {
        logic h_sync;    // active low.
        logic v_sync;    // active low.
        logic h_visible;
        logic v_visible;
    } sync_t;

endpackage
